// ==== list.f ====
rtl/PixelPkg.sv
rtl/ColorInterpolator.sv
rtl/LerpDispatcher.sv
rtl/LerpCollector.sv
rtl/ColorLerpUnit.sv
test/ColorLerpUnit_assertions.sv
test/ColorLerpUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the color blending unit testbench with Verilator, runs it,
# and decides pass or fail by searching the simulation log

set -u
cd "$(dirname "$0")" || exit 1

buildDir=build
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ColorLerpUnitTb \
    -f list.f \
    --Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/simv" +verilator+error+limit+100 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Regression passed" "$logFile"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, exit status $simStatus"
    exit 1
fi

// ==== test/ColorLerpUnitTb.sv ====
// Directed testbench for the color blending unit
// Sends blend requests over the four-phase input side, drains results over the
// four-phase output side and compares each one with a model of the blend rule

module ColorLerpUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    import PixelPkg::*;

    localparam int NumLanes = 4;
    localparam int ClockPeriod = 20;
    // About 240 items at up to 50 cycles each, the back-pressure test is the slow one
    localparam int TimeoutCycles = 240 * 50;

    logic                      aclk;
    logic                      reset;
    logic                      inReq;
    logic [IntensityWidth-1:0] inIntensity;
    logic [PixelWidth-1:0]     inColorA;
    logic [PixelWidth-1:0]     inColorB;
    logic                      inAck;
    logic                      outReq;
    logic [PixelWidth-1:0]     outColor;
    logic                      outAck;

    // Results still owed by the DUT, oldest first
    logic [PixelWidth-1:0] expectedQ [$];
    int cycleCount = 0;
    int unsigned seedValue;

    ColorLerpUnit #(
        .NumLanes(NumLanes)
    ) u_dut (
        .aclk(aclk),
        .reset(reset),
        .inReq(inReq),
        .inIntensity(inIntensity),
        .inColorA(inColorA),
        .inColorB(inColorB),
        .inAck(inAck),
        .outReq(outReq),
        .outColor(outColor),
        .outAck(outAck)
    );

    initial
    begin
        aclk = 1'b0;
        forever #(ClockPeriod / 2) aclk = ~aclk;
    end

    // Guards against a handshake that never completes
    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles)
        begin
            $display("Timeout: the tests did not finish within %0d clock cycles", TimeoutCycles);
            $display("Regression failed");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Per channel: (i * a + (255 - i) * b + 255) / 256, clamped to 255
    // Only the upper intensity byte counts as i
    function automatic logic [PixelWidth-1:0] blendReference(
        input logic [IntensityWidth-1:0] intensity,
        input logic [PixelWidth-1:0]     colorA,
        input logic [PixelWidth-1:0]     colorB
    );
        logic [PixelWidth-1:0] result;
        int weight;
        int chanA;
        int chanB;
        int mix;
        weight = int'(intensity[15:8]);
        result = '0;
        for (int c = 0; c < 4; c++)
        begin
            chanA = int'(colorA[c*8 +: 8]);
            chanB = int'(colorB[c*8 +: 8]);
            mix = (weight * chanA + (255 - weight) * chanB + 255) / 256;
            if (mix > 255)
                mix = 255;
            result[c*8 +: 8] = 8'(mix);
        end
        return result;
    endfunction

    // Four-phase send, the expected result is queued before the request goes up
    task automatic sendItem(
        input logic [IntensityWidth-1:0] intensity,
        input logic [PixelWidth-1:0]     colorA,
        input logic [PixelWidth-1:0]     colorB,
        input logic [PixelWidth-1:0]     expected
    );
        expectedQ.push_back(expected);
        @(posedge aclk);
        inIntensity <= intensity;
        inColorA <= colorA;
        inColorB <= colorB;
        inReq <= 1'b1;
        @(posedge aclk);
        while (!inAck)
            @(posedge aclk);
        inReq <= 1'b0;
        @(posedge aclk);
        while (inAck)
            @(posedge aclk);
    endtask

    task automatic sendRandom();
        logic [IntensityWidth-1:0] intensity;
        logic [PixelWidth-1:0]     colorA;
        logic [PixelWidth-1:0]     colorB;
        intensity = 16'($urandom());
        colorA = $urandom();
        colorB = $urandom();
        sendItem(intensity, colorA, colorB, blendReference(intensity, colorA, colorB));
    endtask

    // Four-phase receive, waits up to maxDelay cycles before acknowledging
    task automatic receiveItem(input int maxDelay);
        logic [PixelWidth-1:0] expected;
        int delay;
        delay = (maxDelay > 0) ? int'($urandom_range(maxDelay, 0)) : 0;
        @(posedge aclk);
        while (!outReq)
            @(posedge aclk);
        repeat (delay) @(posedge aclk);
        assert (expectedQ.size() > 0)
        else abortRun("The DUT returned a result although no request was outstanding");
        expected = expectedQ.pop_front();
        assert (outColor === expected)
        else abortRun($sformatf("[ERROR] %0t: outColor expected %08h, got %08h",
            $time, expected, outColor));
        outAck <= 1'b1;
        @(posedge aclk);
        while (outReq)
            @(posedge aclk);
        outAck <= 1'b0;
    endtask

    task automatic checkQueueEmpty(input string testName);
        assert (expectedQ.size() == 0)
        else abortRun($sformatf("%s ended with %0d results never delivered",
            testName, expectedQ.size()));
    endtask

    task automatic checkResetState();
        repeat (3) @(posedge aclk);
        assert (inAck === 1'b0 && outReq === 1'b0)
        else abortRun($sformatf("[ERROR] %0t: after reset inAck=%b outReq=%b, both should be low",
            $time, inAck, outReq));
    endtask

    // Full intensity gives color A and zero intensity gives color B, bit for bit
    task automatic checkEndPoints();
        logic [PixelWidth-1:0] colorA;
        logic [PixelWidth-1:0] colorB;
        for (int n = 0; n < 4; n++)
        begin
            colorA = (n == 0) ? 32'hFFFF_FFFF : $urandom();
            colorB = (n == 0) ? 32'h0000_0000 : $urandom();
            sendItem(16'hFFFF, colorA, colorB, colorA);
            receiveItem(0);
            sendItem(16'h0000, colorA, colorB, colorB);
            receiveItem(0);
        end
        checkQueueEmpty("End point test");
    endtask

    // One item at a time, the random low intensity byte must not matter
    task automatic checkRandomBlends();
        for (int n = 0; n < 100; n++)
        begin
            sendRandom();
            receiveItem(0);
        end
        checkQueueEmpty("Random blend test");
    endtask

    // Producer and consumer run together, so each send overlaps the drain of the last result
    task automatic checkOrdering();
        fork
            for (int n = 0; n < 40; n++)
                sendRandom();
            repeat (40) receiveItem(0);
        join
        checkQueueEmpty("Ordering test");
    endtask

    // A slow consumer fills every slot and the producer has to stall
    task automatic checkBackPressure();
        fork
            for (int n = 0; n < 60; n++)
                sendRandom();
            repeat (60) receiveItem(30);
        join
        checkQueueEmpty("Back-pressure test");
    endtask

    initial
    begin
        seedValue = $urandom(49);
        reset = 1'b1;
        inReq = 1'b0;
        inIntensity = '0;
        inColorA = '0;
        inColorB = '0;
        outAck = 1'b0;
        repeat (5) @(posedge aclk);
        reset <= 1'b0;

        checkResetState();
        checkEndPoints();
        checkRandomBlends();
        checkOrdering();
        checkBackPressure();

        repeat (5) @(posedge aclk);
        if (u_dut.u_assertions.violationCount == 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("Regression failed");
            $fatal(1, "Protocol checks reported %0d violations",
                u_dut.u_assertions.violationCount);
        end
    end

endmodule

// ==== test/ColorLerpUnit_assertions.sv ====
// Handshake and protocol checks for the color blending unit
// Bound into every ColorLerpUnit instance, the testbench reads the violation count

module ColorLerpUnitAssertions #(
    parameter int NumLanes = 4
)
(
    input logic                            aclk,
    input logic                            reset,
    input logic                            inReq,
    input logic                            inAck,
    input logic                            outReq,
    input logic                            outAck,
    input logic [PixelPkg::PixelWidth-1:0] outColor,
    input logic [NumLanes-1:0]             laneIssue
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed checks so far
    int violationCount = 0;

    // A result request stays up until the consumer answers it
    outReqHeld: assert property (@(posedge aclk) disable iff (reset)
        outReq && !outAck |=> outReq)
    else
    begin
        violationCount++;
        $error("outReq was lowered before outAck arrived");
    end

    // The presented pixel does not move while the request is pending
    outColorStable: assert property (@(posedge aclk) disable iff (reset)
        outReq && !outAck |=> $stable(outColor))
    else
    begin
        violationCount++;
        $error("outColor changed while outReq was high");
    end

    // Input ack returns to zero only once the producer has let go
    inAckHeld: assert property (@(posedge aclk) disable iff (reset)
        inAck && inReq |=> inAck)
    else
    begin
        violationCount++;
        $error("inAck fell while inReq was still high");
    end

    // A single lane takes each item
    issueOneHot: assert property (@(posedge aclk) disable iff (reset)
        $onehot0(laneIssue))
    else
    begin
        violationCount++;
        $error("More than one laneIssue bit was set");
    end

endmodule

bind ColorLerpUnit ColorLerpUnitAssertions #(
    .NumLanes(NumLanes)
) u_assertions (
    .aclk(aclk),
    .reset(reset),
    .inReq(inReq),
    .inAck(inAck),
    .outReq(outReq),
    .outAck(outAck),
    .outColor(outColor),
    .laneIssue(laneIssue)
);

// ==== rtl/ColorLerpUnit.sv ====
// Top level of the color blending unit
// Blends pixel pairs by intensity on NumLanes parallel two-stage lanes
// Both outer sides use four-phase req/ack, results leave in request order

module ColorLerpUnit #(
    parameter int NumLanes = 4
)
(
    input  logic                                aclk,
    input  logic                                reset,
    input  logic                                inReq,
    input  logic [PixelPkg::IntensityWidth-1:0] inIntensity,
    input  logic [PixelPkg::PixelWidth-1:0]     inColorA,
    input  logic [PixelPkg::PixelWidth-1:0]     inColorB,
    output logic                                inAck,
    output logic                                outReq,
    output logic [PixelPkg::PixelWidth-1:0]     outColor,
    input  logic                                outAck
);
    import PixelPkg::*;

    // Issue side, shared by all lanes
    logic [NumLanes-1:0]                 laneIssue;
    logic [IntensityWidth-1:0]           laneIntensity;
    logic [PixelWidth-1:0]               laneColorA;
    logic [PixelWidth-1:0]               laneColorB;
    // Result side, one entry per lane
    logic [NumLanes-1:0]                 laneDone;
    logic [NumLanes-1:0][PixelWidth-1:0] laneColor;
    logic [NumLanes-1:0]                 laneFree;

    LerpDispatcher #(
        .NumLanes(NumLanes)
    ) u_dispatcher (
        .aclk(aclk),
        .reset(reset),
        .inReq(inReq),
        .inIntensity(inIntensity),
        .inColorA(inColorA),
        .inColorB(inColorB),
        .laneFree(laneFree),
        .inAck(inAck),
        .laneIssue(laneIssue),
        .laneIntensity(laneIntensity),
        .laneColorA(laneColorA),
        .laneColorB(laneColorB)
    );

    // Every lane watches the shared buses and reacts only to its own issue bit
    for (genvar k = 0; k < NumLanes; k++)
    begin : gLane
        ColorInterpolator u_lane (
            .aclk(aclk),
            .reset(reset),
            .inValid(laneIssue[k]),
            .intensity(laneIntensity),
            .colorA(laneColorA),
            .colorB(laneColorB),
            .outValid(laneDone[k]),
            .mixedColor(laneColor[k])
        );
    end

    LerpCollector #(
        .NumLanes(NumLanes)
    ) u_collector (
        .aclk(aclk),
        .reset(reset),
        .laneIssue(laneIssue),
        .laneDone(laneDone),
        .laneColor(laneColor),
        .outAck(outAck),
        .laneFree(laneFree),
        .outReq(outReq),
        .outColor(outColor)
    );

endmodule

// ==== rtl/LerpCollector.sv ====
// Output side of the color blending unit
// Keeps one result slot per blend lane and drains the slots in round-robin order
// over a four-phase req/ack handshake, so results leave in arrival order
// A slot is reserved at issue, filled when its lane finishes and freed on ack

module LerpCollector #(
    parameter int NumLanes = 4
)
(
    input  logic                                           aclk,
    input  logic                                           reset,
    input  logic [NumLanes-1:0]                            laneIssue,
    input  logic [NumLanes-1:0]                            laneDone,
    input  logic [NumLanes-1:0][PixelPkg::PixelWidth-1:0]  laneColor,
    input  logic                                           outAck,
    output logic [NumLanes-1:0]                            laneFree,
    output logic                                           outReq,
    output logic [PixelPkg::PixelWidth-1:0]                outColor
);
    import PixelPkg::*;

    localparam int PtrWidth = $clog2(NumLanes);

    typedef enum logic [1:0]
    {
        SlotFree,
        SlotReserved,
        SlotFull
    } SlotState;

    SlotState              slotState [NumLanes];
    logic [PixelWidth-1:0] slotData [NumLanes];
    // Slot whose result goes out next
    logic [PtrWidth-1:0]   readPtr;
    logic                  headReady;
    logic                  present;
    logic                  drain;

    // The head result counts as ready in the cycle its lane finishes,
    // which saves a cycle of latency on an idle output
    assign headReady = (slotState[readPtr] == SlotFull) || laneDone[readPtr];
    // A new request may only start after the consumer has dropped its ack
    assign present = !outReq && !outAck && headReady;
    assign drain = outReq && outAck;

    always_comb
    begin
        for (int k = 0; k < NumLanes; k++)
        begin
            laneFree[k] = (slotState[k] == SlotFree);
        end
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            for (int k = 0; k < NumLanes; k++)
            begin
                slotState[k] <= SlotFree;
            end
            readPtr <= '0;
            outReq <= 1'b0;
        end
        else
        begin
            for (int k = 0; k < NumLanes; k++)
            begin
                if (laneIssue[k])
                    slotState[k] <= SlotReserved;
                else if (laneDone[k])
                    slotState[k] <= SlotFull;
                else if (drain && readPtr == PtrWidth'(k))
                    slotState[k] <= SlotFree;
            end

            if (present)
            begin
                outReq <= 1'b1;
            end
            else if (drain)
            begin
                // Ack seen, drop the request and move on to the next lane
                outReq <= 1'b0;
                readPtr <= (readPtr == PtrWidth'(NumLanes - 1)) ? '0 : readPtr + 1'b1;
            end
        end
    end

    // Result storage and the output register
    always_ff @(posedge aclk)
    begin
        for (int k = 0; k < NumLanes; k++)
        begin
            if (laneDone[k])
                slotData[k] <= laneColor[k];
        end
        // outColor only changes when a request is raised, so it holds through the handshake
        if (present)
        begin
            outColor <= (slotState[readPtr] == SlotFull) ? slotData[readPtr] : laneColor[readPtr];
        end
    end

endmodule

// ==== rtl/LerpDispatcher.sv ====
// Input side of the color blending unit
// Accepts blend requests over a four-phase req/ack handshake
// and hands each one to the blend lanes in round-robin order
// A request waits until the result slot of the next lane is free

module LerpDispatcher #(
    parameter int NumLanes = 4
)
(
    input  logic                                aclk,
    input  logic                                reset,
    input  logic                                inReq,
    input  logic [PixelPkg::IntensityWidth-1:0] inIntensity,
    input  logic [PixelPkg::PixelWidth-1:0]     inColorA,
    input  logic [PixelPkg::PixelWidth-1:0]     inColorB,
    input  logic [NumLanes-1:0]                 laneFree,
    output logic                                inAck,
    output logic [NumLanes-1:0]                 laneIssue,
    output logic [PixelPkg::IntensityWidth-1:0] laneIntensity,
    output logic [PixelPkg::PixelWidth-1:0]     laneColorA,
    output logic [PixelPkg::PixelWidth-1:0]     laneColorB
);
    localparam int PtrWidth = $clog2(NumLanes);

    // Lane that receives the next accepted item
    logic [PtrWidth-1:0] issuePtr;
    logic                issueNow;

    // Accept a fresh request only while ack is still low from the last one
    assign issueNow = inReq && !inAck && laneFree[issuePtr];

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            inAck <= 1'b0;
            laneIssue <= '0;
            issuePtr <= '0;
        end
        else
        begin
            // The issue strobe lasts a single cycle
            laneIssue <= '0;
            if (issueNow)
            begin
                inAck <= 1'b1;
                laneIssue[issuePtr] <= 1'b1;
                issuePtr <= (issuePtr == PtrWidth'(NumLanes - 1)) ? '0 : issuePtr + 1'b1;
            end
            else if (inAck && !inReq)
            begin
                // Return to zero once the producer has dropped its request
                inAck <= 1'b0;
            end
        end
    end

    // Shared lane buses, only the lane that sees its issue bit picks them up
    always_ff @(posedge aclk)
    begin
        if (issueNow)
        begin
            laneIntensity <= inIntensity;
            laneColorA <= inColorA;
            laneColorB <= inColorB;
        end
    end

endmodule

// ==== rtl/ColorInterpolator.sv ====
// One blend lane of the color blending unit
// Computes i * colorA + (1.0 - i) * colorB per channel with rounding and clamp
// Two register stages, a result appears two cycles after inValid
// A new item may enter in every cycle

module ColorInterpolator
(
    input  logic                              aclk,
    input  logic                              reset,
    input  logic                              inValid,
    input  logic [PixelPkg::IntensityWidth-1:0] intensity,
    input  logic [PixelPkg::PixelWidth-1:0]     colorA,
    input  logic [PixelPkg::PixelWidth-1:0]     colorB,
    output logic                              outValid,
    output logic [PixelPkg::PixelWidth-1:0]     mixedColor
);
    import PixelPkg::*;

    localparam int NumChannels = PixelWidth / SubPixelWidth;
    localparam int ProductWidth = 2 * SubPixelWidth;
    // One extra bit so the sum plus rounding offset never wraps
    localparam int SumWidth = ProductWidth + 1;
    localparam int ChannelPos [NumChannels] = '{ColorRPos, ColorGPos, ColorBPos, ColorAPos};

    // Weight of color A, taken from the upper intensity byte
    logic [SubPixelWidth-1:0] weight;
    // Weight of color B, the complement of the A weight
    logic [SubPixelWidth-1:0] weightInv;

    // Stage one products, one per channel and per color
    logic [ProductWidth-1:0] prodA [NumChannels];
    logic [ProductWidth-1:0] prodB [NumChannels];
    logic                    stageValid;

    assign weight = intensity[IntensityWidth-1 -: SubPixelWidth];
    assign weightInv = SubPixelWidth'(OneDotZero) - weight;

    // Stage one multiplies every channel by its weight
    always_ff @(posedge aclk)
    begin
        for (int c = 0; c < NumChannels; c++)
        begin
            prodA[c] <= ProductWidth'(weight)
                * ProductWidth'(colorA[ChannelPos[c] +: SubPixelWidth]);
            prodB[c] <= ProductWidth'(weightInv)
                * ProductWidth'(colorB[ChannelPos[c] +: SubPixelWidth]);
        end
    end

    // Stage two adds both products plus the rounding offset
    // The upper byte of the 16 bit result is the blended channel
    always_ff @(posedge aclk)
    begin : resultStage
        logic [SumWidth-1:0] sum;
        for (int c = 0; c < NumChannels; c++)
        begin
            sum = SumWidth'(prodA[c]) + SumWidth'(prodB[c]) + SumWidth'(OneDotZero);
            // Saturate when the sum spills into bit 16
            mixedColor[ChannelPos[c] +: SubPixelWidth] <= sum[ProductWidth]
                ? SubPixelWidth'(OneDotZero)
                : sum[ProductWidth-1 -: SubPixelWidth];
        end
    end

    // The valid bit travels alongside the data through both stages
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            stageValid <= 1'b0;
            outValid <= 1'b0;
        end
        else
        begin
            stageValid <= inValid;
            outValid <= stageValid;
        end
    end

endmodule

// ==== rtl/PixelPkg.sv ====
// Shared pixel format constants for the color blending datapath
// Describes the RGBA8888 layout and the fixed-point blend constant
// Imported by every RTL block that works on pixel or intensity words

package PixelPkg;

    // Width of a single color channel
    parameter int SubPixelWidth = 8;

    // Four channels make one RGBA pixel
    parameter int PixelWidth = SubPixelWidth * 4;

    // The producer hands over a 16 bit intensity
    // Only its upper byte takes part in the blend, the low byte is ignored
    parameter int IntensityWidth = 16;

    // Bit positions of the channels inside a pixel word
    // Red sits in the most significant byte, alpha in the least significant one
    parameter int ColorRPos = 24;
    parameter int ColorGPos = 16;
    parameter int ColorBPos = 8;
    parameter int ColorAPos = 0;

    // Fixed-point 1.0 of one channel
    // It serves as the base of the complement weight (1.0 - i)
    // and also as the rounding offset added before the final shift
    parameter int OneDotZero = 255;

endpackage
